// ==== rtl/cpu_params.svh ====
// RV32I encodings only; a subset of opcodes and funct codes is decoded, everything else halts
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// major opcodes
`define OPCODE_OP       7'b0110011
`define OPCODE_OP_IMM   7'b0010011
`define OPCODE_LUI      7'b0110111
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011
`define OPCODE_BRANCH   7'b1100011
`define OPCODE_SYSTEM   7'b1110011

// funct3 codes
`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_WORD 3'b010

// instruction bit that turns ADD into SUB
`define F7_SUB_BIT 30

// write-back source
`define WB_ALU 2'b00
`define WB_MEM 2'b01
`define WB_IMM 2'b10

// ALU operations
`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_OR  4'd3
`define ALU_XOR 4'd4
`define ALU_SLT 4'd5
`define ALU_SLL 4'd6
`define ALU_SRL 4'd7

`define RESET_PC  32'h0000_0000
// ADDI x0,x0,0
`define NOP_INSTR 32'h0000_0013

`endif

// ==== rtl/cpuPkg.sv ====
// shared types for the pipeline; widths are fixed by RV32I, no parameters
`default_nettype none

package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regIdxT;
    typedef logic [1:0]  wbSelT;
    typedef logic [3:0]  aluOpT;

    // decoded control, travels with the instruction into EX
    typedef struct packed {
        logic  regWrEn;
        logic  memWrEn;
        logic  memRdEn;
        wbSelT wbSel;
        aluOpT aluOp;
        logic  aluSrcImm;
        logic  isBranch;
        logic  branchNe;
        logic  halt;
    } ctrlT;

    typedef struct packed {
        logic valid;
        wordT pc;
        wordT instr;
    } ifIdT;

    typedef struct packed {
        logic   valid;
        wordT   pc;
        wordT   rs1Data;
        wordT   rs2Data;
        wordT   imm;
        regIdxT rd;
        ctrlT   ctrl;
    } idExT;

    // only the control that MEM and WB still need
    typedef struct packed {
        logic   valid;
        wordT   aluResult;
        wordT   storeData;
        wordT   imm;
        regIdxT rd;
        logic   regWrEn;
        logic   memWrEn;
        wbSelT  wbSel;
        logic   halt;
    } exMemT;

    typedef struct packed {
        logic   valid;
        wordT   result;
        regIdxT rd;
        logic   regWrEn;
        logic   halt;
    } memWbT;

    // register file write port, also the retire bus
    typedef struct packed {
        logic   en;
        regIdxT rd;
        wordT   data;
    } retireT;

endpackage

`default_nettype wire

// ==== rtl/regFile.sv ====
// 32 x 32 register file, x0 reads zero, same-cycle write is bypassed to both read ports
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                   CLK,
    input  wire                   rstN,
    input  wire cpuPkg::regIdxT   rs1Idx,
    input  wire cpuPkg::regIdxT   rs2Idx,
    output cpuPkg::wordT          rs1Data,
    output cpuPkg::wordT          rs2Data,
    input  wire cpuPkg::retireT   wr
);

    cpuPkg::wordT regs [32];

    function automatic cpuPkg::wordT readPort(input cpuPkg::regIdxT idx);
        if (idx == '0) begin
            return '0;
        end
        // write-through keeps WB results visible to ID in the same cycle
        if (wr.en && wr.rd == idx) begin
            return wr.data;
        end
        return regs[idx];
    endfunction

    // read ports follow the write port and the array as well as the index
    always_comb begin
        rs1Data = readPort(rs1Idx);
        rs2Data = readPort(rs2Idx);
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
// RAW detection against EX and MEM only; WB is covered by the register file bypass
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
    input  wire                   ifIdValid,
    input  wire cpuPkg::regIdxT   rs1Idx,
    input  wire cpuPkg::regIdxT   rs2Idx,
    input  wire                   usesRs2,
    input  wire cpuPkg::regIdxT   exDst,
    input  wire                   exWr,
    input  wire cpuPkg::regIdxT   memDst,
    input  wire                   memWr,
    output logic                  stall
);

    logic rs1Hit;
    logic rs2Hit;

    // rs1 is treated as always read, which only costs spare stalls for LUI
    assign rs1Hit = (rs1Idx != '0)
                 && ((exWr && exDst == rs1Idx) || (memWr && memDst == rs1Idx));
    assign rs2Hit = usesRs2 && (rs2Idx != '0)
                 && ((exWr && exDst == rs2Idx) || (memWr && memDst == rs2Idx));

    assign stall = ifIdValid && (rs1Hit || rs2Hit);

endmodule

`default_nettype wire

// ==== rtl/fetchStage.sv ====
// PC and IF/ID register; redirect wins over stall and halt freeze
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module fetchStage (
    input  wire                 CLK,
    input  wire                 rstN,
    input  wire                 stall,
    input  wire                 haltPending,
    input  wire                 redirect,
    input  wire cpuPkg::wordT   redirectPc,
    output cpuPkg::wordT        imemAddr,
    input  wire cpuPkg::wordT   imemData,
    output cpuPkg::ifIdT        ifId
);

    cpuPkg::wordT pc;

    assign imemAddr = pc;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            pc         <= `RESET_PC;
            ifId.valid <= 1'b0;
            ifId.pc    <= `RESET_PC;
            ifId.instr <= `NOP_INSTR;
        end else if (redirect) begin
            // squash the wrong-path fetch
            pc         <= redirectPc;
            ifId.valid <= 1'b0;
            ifId.instr <= `NOP_INSTR;
        end else if (!(stall || haltPending)) begin
            pc         <= pc + 32'd4;
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= imemData;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/decodeStage.sv ====
// decodes the kept RV32I subset only; any other encoding, ECALL included, raises halt
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module decodeStage (
    input  wire                 CLK,
    input  wire                 rstN,
    input  wire cpuPkg::ifIdT   ifId,
    input  wire                 stall,
    input  wire                 haltPending,
    input  wire                 redirect,
    output cpuPkg::regIdxT      rs1Idx,
    output cpuPkg::regIdxT      rs2Idx,
    input  wire cpuPkg::wordT   rs1Data,
    input  wire cpuPkg::wordT   rs2Data,
    output logic                usesRs2,
    output cpuPkg::idExT        idEx
);

    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic [6:0]     funct7;
    cpuPkg::regIdxT rd;
    cpuPkg::ctrlT   ctrl;
    cpuPkg::wordT   imm;
    logic           bubble;

    assign opcode = ifId.instr[6:0];
    assign rd     = ifId.instr[11:7];
    assign funct3 = ifId.instr[14:12];
    assign rs1Idx = ifId.instr[19:15];
    assign rs2Idx = ifId.instr[24:20];
    assign funct7 = ifId.instr[31:25];

    // R, S and B formats read rs2
    assign usesRs2 = (opcode == `OPCODE_OP) || (opcode == `OPCODE_STORE)
                  || (opcode == `OPCODE_BRANCH);

    always_comb begin
        ctrl = '0;
        imm  = {{20{ifId.instr[31]}}, ifId.instr[31:20]};
        case (opcode)
            `OPCODE_OP: begin
                ctrl.regWrEn = 1'b1;
                ctrl.wbSel   = `WB_ALU;
                case (funct3)
                    `F3_ADD: ctrl.aluOp = ifId.instr[`F7_SUB_BIT] ? `ALU_SUB : `ALU_ADD;
                    `F3_SLL: ctrl.aluOp = `ALU_SLL;
                    `F3_SLT: ctrl.aluOp = `ALU_SLT;
                    `F3_XOR: ctrl.aluOp = `ALU_XOR;
                    `F3_SRL: ctrl.aluOp = `ALU_SRL;
                    `F3_OR:  ctrl.aluOp = `ALU_OR;
                    `F3_AND: ctrl.aluOp = `ALU_AND;
                    default: ctrl.halt  = 1'b1;
                endcase
                // only SUB may set a funct7 bit
                if (funct7 == 7'b0100000 && funct3 != `F3_ADD) begin
                    ctrl.halt = 1'b1;
                end else if (funct7 != 7'b0100000 && funct7 != 7'b0000000) begin
                    ctrl.halt = 1'b1;
                end
            end
            `OPCODE_OP_IMM: begin
                ctrl.regWrEn   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSel     = `WB_ALU;
                case (funct3)
                    `F3_ADD: ctrl.aluOp = `ALU_ADD;
                    `F3_SLT: ctrl.aluOp = `ALU_SLT;
                    `F3_XOR: ctrl.aluOp = `ALU_XOR;
                    `F3_OR:  ctrl.aluOp = `ALU_OR;
                    `F3_AND: ctrl.aluOp = `ALU_AND;
                    default: ctrl.halt  = 1'b1;
                endcase
            end
            `OPCODE_LUI: begin
                ctrl.regWrEn = 1'b1;
                ctrl.wbSel   = `WB_IMM;
                imm          = {ifId.instr[31:12], 12'b0};
            end
            `OPCODE_LOAD: begin
                ctrl.regWrEn   = 1'b1;
                ctrl.memRdEn   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.wbSel     = `WB_MEM;
                ctrl.halt      = (funct3 != `F3_WORD);
            end
            `OPCODE_STORE: begin
                ctrl.memWrEn   = (funct3 == `F3_WORD);
                ctrl.aluSrcImm = 1'b1;
                ctrl.halt      = (funct3 != `F3_WORD);
                imm = {{20{ifId.instr[31]}}, ifId.instr[31:25], ifId.instr[11:7]};
            end
            `OPCODE_BRANCH: begin
                ctrl.isBranch = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                ctrl.branchNe = (funct3 == `F3_BNE);
                ctrl.halt     = !ctrl.isBranch;
                imm = {{19{ifId.instr[31]}}, ifId.instr[31], ifId.instr[7],
                       ifId.instr[30:25], ifId.instr[11:8], 1'b0};
            end
            // ECALL and every unknown opcode
            default: ctrl.halt = 1'b1;
        endcase
        // a halting instruction must not write anything
        if (ctrl.halt) begin
            ctrl.regWrEn = 1'b0;
            ctrl.memWrEn = 1'b0;
        end
    end

    assign bubble = stall || redirect || haltPending || !ifId.valid;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            idEx <= '0;
        end else if (bubble) begin
            idEx <= '0;
        end else begin
            idEx.valid   <= 1'b1;
            idEx.pc      <= ifId.pc;
            idEx.rs1Data <= rs1Data;
            idEx.rs2Data <= rs2Data;
            idEx.imm     <= imm;
            idEx.rd      <= rd;
            idEx.ctrl    <= ctrl;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/executeStage.sv ====
// ALU and branch resolution; only BEQ and BNE redirect, target is pc + imm
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module executeStage (
    input  wire                 CLK,
    input  wire                 rstN,
    input  wire cpuPkg::idExT   idEx,
    output cpuPkg::exMemT       exMem,
    output logic                redirect,
    output cpuPkg::wordT        redirectPc
);

    cpuPkg::wordT opA;
    cpuPkg::wordT opB;
    cpuPkg::wordT aluResult;
    logic         equal;

    assign opA = idEx.rs1Data;
    assign opB = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.rs2Data;

    always_comb begin
        case (idEx.ctrl.aluOp)
            `ALU_ADD: aluResult = opA + opB;
            `ALU_SUB: aluResult = opA - opB;
            `ALU_AND: aluResult = opA & opB;
            `ALU_OR:  aluResult = opA | opB;
            `ALU_XOR: aluResult = opA ^ opB;
            `ALU_SLT: aluResult = {31'b0, $signed(opA) < $signed(opB)};
            `ALU_SLL: aluResult = opA << opB[4:0];
            `ALU_SRL: aluResult = opA >> opB[4:0];
            default:  aluResult = '0;
        endcase
    end

    // branch compare always uses the register operands
    assign equal      = (idEx.rs1Data == idEx.rs2Data);
    assign redirect   = idEx.valid && idEx.ctrl.isBranch && (equal ^ idEx.ctrl.branchNe);
    assign redirectPc = idEx.pc + idEx.imm;

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            exMem <= '0;
        end else begin
            exMem.valid     <= idEx.valid;
            exMem.aluResult <= aluResult;
            exMem.storeData <= idEx.rs2Data;
            exMem.imm       <= idEx.imm;
            exMem.rd        <= idEx.rd;
            exMem.regWrEn   <= idEx.ctrl.regWrEn;
            exMem.memWrEn   <= idEx.ctrl.memWrEn;
            exMem.wbSel     <= idEx.ctrl.wbSel;
            exMem.halt      <= idEx.ctrl.halt;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/memWbStage.sv ====
// MEM/WB register and write-back; halt stays set until reset
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module memWbStage (
    input  wire                  CLK,
    input  wire                  rstN,
    input  wire cpuPkg::exMemT   exMem,
    input  wire cpuPkg::wordT    dmemRdData,
    output cpuPkg::memWbT        memWb,
    output cpuPkg::retireT       retire,
    output logic                 halt
);

    cpuPkg::wordT result;

    always_comb begin
        case (exMem.wbSel)
            `WB_MEM: result = dmemRdData;
            `WB_IMM: result = exMem.imm;
            default: result = exMem.aluResult;
        endcase
    end

    always_ff @(posedge CLK or negedge rstN) begin
        if (!rstN) begin
            memWb <= '0;
            halt  <= 1'b0;
        end else begin
            memWb.valid   <= exMem.valid;
            memWb.result  <= result;
            memWb.rd      <= exMem.rd;
            memWb.regWrEn <= exMem.regWrEn;
            memWb.halt    <= exMem.halt;
            if (memWb.valid && memWb.halt) begin
                halt <= 1'b1;
            end
        end
    end

    // x0 writes and the halting instruction never show up on retire
    assign retire.en   = memWb.valid && memWb.regWrEn && !memWb.halt && (memWb.rd != '0);
    assign retire.rd   = memWb.rd;
    assign retire.data = memWb.result;

endmodule

`default_nettype wire

// ==== rtl/pipelinedCpu.sv ====
// five-stage RV32I subset core; memories are external with combinational reads, no forwarding
`timescale 1ns/1ps
`default_nettype none

module pipelinedCpu (
    input  wire                 CLK,
    input  wire                 rstN,
    output cpuPkg::wordT        imemAddr,
    input  wire cpuPkg::wordT   imemData,
    output cpuPkg::wordT        dmemAddr,
    output cpuPkg::wordT        dmemWrData,
    output logic                dmemWrEn,
    input  wire cpuPkg::wordT   dmemRdData,
    output cpuPkg::retireT      retire,
    output logic                halt
);

    cpuPkg::ifIdT   ifId;
    cpuPkg::idExT   idEx;
    cpuPkg::exMemT  exMem;
    cpuPkg::memWbT  memWb;
    cpuPkg::regIdxT rs1Idx;
    cpuPkg::regIdxT rs2Idx;
    cpuPkg::wordT   rs1Data;
    cpuPkg::wordT   rs2Data;
    cpuPkg::wordT   redirectPc;
    logic           redirect;
    logic           stall;
    logic           usesRs2;
    logic           haltPending;

    // any halt in flight, or already retired, freezes the front end
    assign haltPending = (idEx.valid & idEx.ctrl.halt) | (exMem.valid & exMem.halt)
                       | (memWb.valid & memWb.halt) | halt;

    assign dmemAddr   = exMem.aluResult;
    assign dmemWrData = exMem.storeData;
    assign dmemWrEn   = exMem.valid & exMem.memWrEn;

    fetchStage fetch (
        .CLK(CLK), .rstN(rstN),
        .stall(stall), .haltPending(haltPending),
        .redirect(redirect), .redirectPc(redirectPc),
        .imemAddr(imemAddr), .imemData(imemData),
        .ifId(ifId)
    );

    decodeStage decode (
        .CLK(CLK), .rstN(rstN),
        .ifId(ifId), .stall(stall), .haltPending(haltPending), .redirect(redirect),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .usesRs2(usesRs2), .idEx(idEx)
    );

    regFile regs (
        .CLK(CLK), .rstN(rstN),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx),
        .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wr(retire)
    );

    hazardUnit hazards (
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx),
        .ifIdValid(ifId.valid), .usesRs2(usesRs2),
        .exDst(idEx.rd), .exWr(idEx.valid & idEx.ctrl.regWrEn),
        .memDst(exMem.rd), .memWr(exMem.valid & exMem.regWrEn),
        .stall(stall)
    );

    executeStage execute (
        .CLK(CLK), .rstN(rstN),
        .idEx(idEx), .exMem(exMem),
        .redirect(redirect), .redirectPc(redirectPc)
    );

    memWbStage memWbS (
        .CLK(CLK), .rstN(rstN),
        .exMem(exMem), .dmemRdData(dmemRdData),
        .memWb(memWb), .retire(retire), .halt(halt)
    );

endmodule

`default_nettype wire

// ==== verif/cpuTb.sv ====
// testbench for pipelinedCpu; both memories hold 256 words and decode only address bits 9:2
`timescale 1ns/1ps
`default_nettype none
`include "cpu_params.svh"

module cpuTb;

    logic                  CLK = 1'b0;
    logic                  rstN = 1'b0;
    cpuPkg::wordT          imemAddr;
    cpuPkg::wordT          imemData = `NOP_INSTR;
    cpuPkg::wordT          dmemAddr;
    cpuPkg::wordT          dmemWrData;
    logic                  dmemWrEn;
    cpuPkg::wordT          dmemRdData = '0;
    cpuPkg::retireT        retire;
    logic                  halt;

    cpuPkg::wordT          imem [256];
    cpuPkg::wordT          dmem [256];
    int                    progLen = 0;
    int                    seed = 45776;
    int unsigned           cycleCount = 0;
    int unsigned           cycleLimit = 100;
    // expected writes in program order, {rd, data} and {addr, data}
    logic [36:0]           retireQ [$];
    logic [63:0]           storeQ [$];

    pipelinedCpu uut (
        .CLK(CLK), .rstN(rstN),
        .imemAddr(imemAddr), .imemData(imemData),
        .dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn),
        .dmemRdData(dmemRdData),
        .retire(retire), .halt(halt)
    );

    always #5 CLK = ~CLK;

    // combinational memory reads, presented just after the edge
    always @(posedge CLK) begin
        #1;
        imemData   = imem[imemAddr[9:2]];
        dmemRdData = dmem[dmemAddr[9:2]];
    end

    function automatic cpuPkg::wordT fillWord(input int idx);
        return {idx[15:0] ^ 16'hC3A5, ~idx[15:0]};
    endfunction

    always @(posedge CLK) begin
        if (!rstN) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fillWord(i);
            end
        end else if (dmemWrEn) begin
            dmem[dmemAddr[9:2]] <= dmemWrData;
        end
    end

    task automatic stopWithFailure(input string what);
        $display("error at %0d ns: %s", $time, what);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic valueError(input string sig, input cpuPkg::wordT expV,
                              input cpuPkg::wordT actV);
        stopWithFailure($sformatf("%s expected %h, got %h", sig, expV, actV));
    endtask

    function automatic logic [11:0] randImm();
        cpuPkg::wordT r;
        r = $random(seed);
        return r[11:0];
    endfunction

    // unused words decode as an unknown opcode, so a runaway PC halts
    task automatic clearProgram();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {i[24:0], 7'h7f};
        end
        progLen = 0;
    endtask

    task automatic putWord(input cpuPkg::wordT w);
        imem[progLen] = w;
        progLen = progLen + 1;
    endtask

    task automatic putR(input logic [2:0] f3, input logic sub, input cpuPkg::regIdxT rd,
                        input cpuPkg::regIdxT rs1, input cpuPkg::regIdxT rs2);
        putWord({1'b0, sub, 5'b0, rs2, rs1, f3, rd, `OPCODE_OP});
    endtask

    task automatic putI(input logic [6:0] opc, input logic [2:0] f3, input cpuPkg::regIdxT rd,
                        input cpuPkg::regIdxT rs1, input logic [11:0] imm);
        putWord({imm, rs1, f3, rd, opc});
    endtask

    task automatic putLui(input cpuPkg::regIdxT rd, input logic [19:0] imm);
        putWord({imm, rd, `OPCODE_LUI});
    endtask

    task automatic putSw(input cpuPkg::regIdxT src, input cpuPkg::regIdxT base,
                         input logic [11:0] off);
        putWord({off[11:5], src, base, `F3_WORD, off[4:0], `OPCODE_STORE});
    endtask

    task automatic putBr(input logic [2:0] f3, input cpuPkg::regIdxT rs1,
                         input cpuPkg::regIdxT rs2, input logic [12:0] off);
        putWord({off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPCODE_BRANCH});
    endtask

    task automatic buildMainProgram();
        cpuPkg::wordT rnd;
        // random operands in x1..x6, each ADDI depends on the LUI right before it
        for (int r = 1; r <= 6; r++) begin
            rnd = $random(seed);
            putLui(r[4:0], rnd[31:12]);
            putI(`OPCODE_OP_IMM, `F3_ADD, r[4:0], r[4:0], rnd[11:0]);
        end
        putR(`F3_ADD, 1'b0, 7, 1, 2);
        putR(`F3_ADD, 1'b1, 8, 3, 4);
        putR(`F3_AND, 1'b0, 9, 5, 6);
        putR(`F3_OR, 1'b0, 10, 1, 3);
        putR(`F3_XOR, 1'b0, 11, 2, 4);
        putR(`F3_SLT, 1'b0, 12, 5, 1);
        putR(`F3_SLL, 1'b0, 13, 6, 2);
        putR(`F3_SRL, 1'b0, 14, 3, 5);
        putI(`OPCODE_OP_IMM, `F3_ADD, 15, 1, randImm());
        putI(`OPCODE_OP_IMM, `F3_AND, 16, 2, randImm());
        putI(`OPCODE_OP_IMM, `F3_OR, 17, 3, randImm());
        putI(`OPCODE_OP_IMM, `F3_XOR, 18, 4, randImm());
        putI(`OPCODE_OP_IMM, `F3_SLT, 19, 5, randImm());
        // dependency distances 1, 2 and 3
        putI(`OPCODE_OP_IMM, `F3_ADD, 20, 7, 12'd5);
        putR(`F3_ADD, 1'b0, 21, 20, 8);
        putI(`OPCODE_OP_IMM, `F3_ADD, 23, 1, 12'd1);
        putR(`F3_ADD, 1'b1, 22, 21, 20);
        putI(`OPCODE_OP_IMM, `F3_ADD, 24, 2, 12'd2);
        putI(`OPCODE_OP_IMM, `F3_ADD, 25, 3, 12'd3);
        putR(`F3_XOR, 1'b0, 26, 22, 24);
        // stores, loads back and a load-use
        putI(`OPCODE_OP_IMM, `F3_ADD, 27, 0, 12'h100);
        putSw(7, 27, 12'd0);
        putSw(9, 27, 12'd4);
        putI(`OPCODE_LOAD, `F3_WORD, 28, 27, 12'd0);
        putI(`OPCODE_LOAD, `F3_WORD, 29, 27, 12'd4);
        putR(`F3_ADD, 1'b0, 30, 28, 29);
        putI(`OPCODE_LOAD, `F3_WORD, 31, 27, 12'd8);
        putSw(31, 27, -12'd4);
        // branches, skipped instructions must neither retire nor store
        putBr(`F3_BEQ, 7, 7, 13'd12);
        putI(`OPCODE_OP_IMM, `F3_ADD, 1, 0, 12'd111);
        putSw(1, 27, 12'd0);
        putI(`OPCODE_OP_IMM, `F3_ADD, 2, 0, 12'd7);
        putBr(`F3_BNE, 7, 7, 13'd12);
        putI(`OPCODE_OP_IMM, `F3_ADD, 3, 0, 12'd9);
        putI(`OPCODE_OP_IMM, `F3_ADD, 4, 0, 12'd10);
        putBr(`F3_BNE, 2, 3, 13'd12);
        putI(`OPCODE_OP_IMM, `F3_ADD, 5, 0, 12'd1);
        putSw(5, 27, 12'd4);
        putBr(`F3_BEQ, 2, 3, 13'd8);
        putI(`OPCODE_OP_IMM, `F3_ADD, 6, 0, 12'd3);
        // short backward loop, three passes
        putI(`OPCODE_OP_IMM, `F3_ADD, 10, 0, 12'd3);
        putI(`OPCODE_OP_IMM, `F3_ADD, 10, 10, -12'd1);
        putBr(`F3_BNE, 10, 0, -13'd4);
        // ECALL, then work that must never happen
        putWord(32'h0000_0073);
        putI(`OPCODE_OP_IMM, `F3_ADD, 11, 0, 12'd55);
        putSw(11, 27, 12'd0);
    endtask

    task automatic buildHaltProgram();
        putI(`OPCODE_OP_IMM, `F3_ADD, 1, 0, 12'd5);
        putI(`OPCODE_OP_IMM, `F3_ADD, 2, 1, 12'd3);
        putSw(2, 0, 12'h40);
        // custom-0 opcode, not part of the decoded subset
        putWord(32'h0000_000B);
        putI(`OPCODE_OP_IMM, `F3_ADD, 3, 0, 12'd1);
        putSw(3, 0, 12'h44);
    endtask

    // instruction-level model of the subset, fills both expectation queues
    function automatic void predictWrites();
        cpuPkg::wordT rf [32];
        cpuPkg::wordT mem [256];
        cpuPkg::wordT pc;
        cpuPkg::wordT nextPc;
        cpuPkg::wordT instr;
        cpuPkg::wordT a;
        cpuPkg::wordT b;
        cpuPkg::wordT iImm;
        cpuPkg::wordT sImm;
        cpuPkg::wordT bImm;
        cpuPkg::wordT val;
        cpuPkg::wordT addr;
        logic         wr;
        logic         stop;
        int           steps;
        for (int i = 0; i < 32; i++) begin
            rf[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = fillWord(i);
        end
        retireQ.delete();
        storeQ.delete();
        pc = `RESET_PC;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < 1000) begin
            instr  = imem[pc[9:2]];
            a      = rf[instr[19:15]];
            b      = rf[instr[24:20]];
            iImm   = {{20{instr[31]}}, instr[31:20]};
            sImm   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            bImm   = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            val    = '0;
            wr     = 1'b0;
            nextPc = pc + 32'd4;
            case (instr[6:0])
                `OPCODE_OP: begin
                    wr = 1'b1;
                    case (instr[14:12])
                        `F3_ADD: val = instr[30] ? a - b : a + b;
                        `F3_SLL: val = a << b[4:0];
                        `F3_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        `F3_XOR: val = a ^ b;
                        `F3_SRL: val = a >> b[4:0];
                        `F3_OR:  val = a | b;
                        `F3_AND: val = a & b;
                        default: stop = 1'b1;
                    endcase
                end
                `OPCODE_OP_IMM: begin
                    wr = 1'b1;
                    case (instr[14:12])
                        `F3_ADD: val = a + iImm;
                        `F3_SLT: val = ($signed(a) < $signed(iImm)) ? 32'd1 : 32'd0;
                        `F3_XOR: val = a ^ iImm;
                        `F3_OR:  val = a | iImm;
                        `F3_AND: val = a & iImm;
                        default: stop = 1'b1;
                    endcase
                end
                `OPCODE_LUI: begin
                    wr  = 1'b1;
                    val = {instr[31:12], 12'b0};
                end
                `OPCODE_LOAD: begin
                    wr   = 1'b1;
                    addr = a + iImm;
                    val  = mem[addr[9:2]];
                end
                `OPCODE_STORE: begin
                    addr = a + sImm;
                    mem[addr[9:2]] = b;
                    storeQ.push_back({addr, b});
                end
                `OPCODE_BRANCH: begin
                    if ((a == b) != instr[12]) begin
                        nextPc = pc + bImm;
                    end
                end
                default: stop = 1'b1;
            endcase
            if (!stop && wr && instr[11:7] != 5'd0) begin
                rf[instr[11:7]] = val;
                retireQ.push_back({instr[11:7], val});
            end
            pc = nextPc;
            steps = steps + 1;
        end
    endfunction

    always @(negedge CLK) begin : compareWrites
        logic [36:0] expRet;
        logic [63:0] expSt;
        if (rstN && retire.en) begin
            assert (retireQ.size() != 0)
                else stopWithFailure("a register write retired when none was expected");
            if (retireQ.size() != 0) begin
                expRet = retireQ.pop_front();
                assert (retire.rd == expRet[36:32])
                    else valueError("retire.rd", {27'b0, expRet[36:32]}, {27'b0, retire.rd});
                assert (retire.data == expRet[31:0])
                    else valueError("retire.data", expRet[31:0], retire.data);
            end
        end
        if (rstN && dmemWrEn) begin
            assert (storeQ.size() != 0)
                else stopWithFailure("a data memory write happened when none was expected");
            if (storeQ.size() != 0) begin
                expSt = storeQ.pop_front();
                assert (dmemAddr == expSt[63:32])
                    else valueError("dmemAddr", expSt[63:32], dmemAddr);
                assert (dmemWrData == expSt[31:0])
                    else valueError("dmemWrData", expSt[31:0], dmemWrData);
            end
        end
    end

    // limit scales with program length, restarts at every reset
    always @(posedge CLK) begin
        if (!rstN) begin
            cycleCount <= 0;
        end else begin
            cycleCount <= cycleCount + 1;
            if (cycleCount > cycleLimit) begin
                stopWithFailure($sformatf("no halt within %0d cycles", cycleLimit));
            end
        end
    end

    task automatic runProgram(input string name);
        @(posedge CLK);
        #1;
        rstN = 1'b0;
        predictWrites();
        cycleLimit = 20 * progLen + 100;
        $display("%s: %0d instructions, %0d register writes and %0d stores expected",
                 name, progLen, retireQ.size(), storeQ.size());
        repeat (5) begin
            @(negedge CLK);
            assert (!retire.en && !dmemWrEn && !halt)
                else stopWithFailure("retire, store or halt active during reset");
            // fetch starts from address zero
            assert (imemAddr == 32'h0000_0000)
                else valueError("imemAddr", 32'h0000_0000, imemAddr);
        end
        @(posedge CLK);
        #1;
        rstN = 1'b1;
        @(negedge CLK);
        assert (!retire.en && !dmemWrEn && !halt)
            else stopWithFailure("retire, store or halt active right after reset");
        while (!halt) begin
            @(negedge CLK);
        end
        assert (retireQ.size() == 0 && storeQ.size() == 0)
            else stopWithFailure("halt rose while expected writes were still missing");
        // halt must hold, later instructions stay silent
        repeat (10) begin
            @(negedge CLK);
            assert (halt) else stopWithFailure("halt dropped before the next reset");
        end
    endtask

    initial begin
        clearProgram();
        buildMainProgram();
        runProgram("main program");
        clearProgram();
        buildHaltProgram();
        runProgram("unknown opcode program");
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+rtl
rtl/cpuPkg.sv
rtl/regFile.sv
rtl/hazardUnit.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memWbStage.sv
rtl/pipelinedCpu.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
# compiles and runs cpuTb with Verilator; the exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cpuTb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
    echo "verilator compile returned $status"
    exit $status
fi

./obj_dir/VcpuTb
status=$?
if [ $status -ne 0 ]; then
    echo "simulation returned $status"
    exit $status
fi

exit 0
